// ==== mem_sub_cfg.svh ====
`ifndef MEM_SUB_CFG_SVH
`define MEM_SUB_CFG_SVH

// bus and storage geometry
`define MEM_DATA_W       64
`define MEM_ADDR_W       32
`define MEM_DEPTH_WORDS  256

// derived: word index and byte lane count
`define MEM_IDX_W        $clog2(`MEM_DEPTH_WORDS)
`define MEM_BE_W         (`MEM_DATA_W / 8)

`endif

// ==== mem_sub_pkg.sv ====
`default_nettype none

package mem_sub_pkg;

    // channel owner, one-hot style codes
    typedef enum logic [2:0] {
        GNT_NONE = 3'b000,
        GNT_MEMW = 3'b001,
        GNT_MEMR = 3'b010,
        GNT_IF   = 3'b100
    } grant_e;

    typedef enum logic {
        CH_IDLE = 1'b0,
        CH_BUSY = 1'b1
    } chan_state_e;

    // bytes per beat
    typedef enum logic [2:0] {
        SZ_1 = 3'b000,
        SZ_2 = 3'b001,
        SZ_4 = 3'b010,
        SZ_8 = 3'b011
    } size_e;

endpackage

`default_nettype wire

// ==== burst_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_sub_cfg.svh"

interface burst_if;
    import mem_sub_pkg::*;

    // request side, held steady until last
    logic                   valid;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [7:0]             len;   // beats minus one
    size_e                  size;
    logic [`MEM_DATA_W-1:0] wdata;

    // response side
    logic                   ready; // one pulse per beat
    logic [`MEM_DATA_W-1:0] rdata;
    logic                   last;

    modport arb (
        output valid, addr, len, size, wdata,
        input  ready, rdata, last
    );

    modport eng (
        input  valid, addr, len, size, wdata,
        output ready, rdata, last
    );

endinterface

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_sub_cfg.svh"

module bus_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    // fetch port
    input  logic                   if_valid_i,
    input  logic [`MEM_ADDR_W-1:0] if_addr_i,
    input  logic [7:0]             if_len_i,
    output logic                   if_ready_o,
    output logic [`MEM_DATA_W-1:0] if_data_o,
    output logic                   if_last_o,
    // data read port
    input  logic                   memr_valid_i,
    input  logic [`MEM_ADDR_W-1:0] memr_addr_i,
    input  logic [7:0]             memr_len_i,
    output logic                   memr_ready_o,
    output logic [`MEM_DATA_W-1:0] memr_data_o,
    output logic                   memr_last_o,
    // data write port
    input  logic                   memw_valid_i,
    input  logic [`MEM_ADDR_W-1:0] memw_addr_i,
    input  logic [7:0]             memw_len_i,
    input  mem_sub_pkg::size_e     memw_size_i,
    input  logic [`MEM_DATA_W-1:0] memw_data_i,
    output logic                   memw_ready_o,
    output logic                   memw_last_o,
    // toward the burst engine
    burst_if.arb                   rd_ch,
    burst_if.arb                   wr_ch
);
    import mem_sub_pkg::*;

    chan_state_e rd_state_q;
    chan_state_e rd_state_d;
    grant_e      rd_owner_q;
    grant_e      rd_owner_d;
    grant_e      wr_owner_q;
    logic        gnt_memr;
    logic        gnt_if;
    logic        gnt_memw;

    // read channel owner, data read beats fetch when both wait
    always_comb begin
        rd_state_d = rd_state_q;
        rd_owner_d = rd_owner_q;
        case (rd_state_q)
            CH_IDLE: begin
                if (memr_valid_i) begin
                    rd_state_d = CH_BUSY;
                    rd_owner_d = GNT_MEMR;
                end else if (if_valid_i) begin
                    rd_state_d = CH_BUSY;
                    rd_owner_d = GNT_IF;
                end
            end
            CH_BUSY: begin
                // burst done, or owner dropped valid
                if ((rd_ch.ready && rd_ch.last) || !rd_ch.valid) begin
                    rd_state_d = CH_IDLE;
                    rd_owner_d = GNT_NONE;
                end
            end
            default: begin
                rd_state_d = CH_IDLE;
                rd_owner_d = GNT_NONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state_q <= CH_IDLE;
            rd_owner_q <= GNT_NONE;
            wr_owner_q <= GNT_NONE;
        end else begin
            rd_state_q <= rd_state_d;
            rd_owner_q <= rd_owner_d;
            wr_owner_q <= memw_valid_i ? GNT_MEMW : GNT_NONE; // write side has one client
        end
    end

    assign gnt_memr = (rd_owner_q == GNT_MEMR);
    assign gnt_if   = (rd_owner_q == GNT_IF);
    assign gnt_memw = (wr_owner_q == GNT_MEMW);

    // owner's request onto the read channel
    assign rd_ch.valid = gnt_memr ? memr_valid_i : (gnt_if ? if_valid_i : 1'b0);
    assign rd_ch.addr  = gnt_memr ? memr_addr_i : (gnt_if ? if_addr_i : '0);
    assign rd_ch.len   = gnt_memr ? memr_len_i : (gnt_if ? if_len_i : '0);
    assign rd_ch.size  = SZ_8;     // reads are whole words
    assign rd_ch.wdata = '0;

    // responses only to the owner
    assign memr_ready_o = gnt_memr & rd_ch.ready;
    assign memr_last_o  = gnt_memr & rd_ch.last;
    assign memr_data_o  = gnt_memr ? rd_ch.rdata : '0;
    assign if_ready_o   = gnt_if & rd_ch.ready;
    assign if_last_o    = gnt_if & rd_ch.last;
    assign if_data_o    = gnt_if ? rd_ch.rdata : '0;

    // write channel gated by its grant
    assign wr_ch.valid  = gnt_memw & memw_valid_i;
    assign wr_ch.addr   = gnt_memw ? memw_addr_i : '0;
    assign wr_ch.len    = gnt_memw ? memw_len_i : '0;
    assign wr_ch.size   = gnt_memw ? memw_size_i : SZ_1;
    assign wr_ch.wdata  = gnt_memw ? memw_data_i : '0;
    assign memw_ready_o = gnt_memw & wr_ch.ready;
    assign memw_last_o  = gnt_memw & wr_ch.last;

endmodule

`default_nettype wire

// ==== burst_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_sub_cfg.svh"

module burst_engine (
    input  logic                   clk,
    input  logic                   rst,
    burst_if.eng                   rd_ch,
    burst_if.eng                   wr_ch,
    // memory array ports
    output logic                   mem_rd_en_o,
    output logic [`MEM_IDX_W-1:0]  mem_rd_addr_o,
    input  logic [`MEM_DATA_W-1:0] mem_rd_data_i,
    output logic                   mem_wr_en_o,
    output logic [`MEM_IDX_W-1:0]  mem_wr_addr_o,
    output logic [`MEM_BE_W-1:0]   mem_wr_be_o,
    output logic [`MEM_DATA_W-1:0] mem_wr_data_o
);
    import mem_sub_pkg::*;

    localparam int BE_W = `MEM_BE_W;

    chan_state_e            rd_state_q;
    logic [`MEM_ADDR_W-1:0] rd_addr_q;    // next address to issue
    logic [8:0]             rd_issued_q;  // reads sent to the array
    logic [7:0]             rd_beat_q;    // beats returned
    logic                   rd_pend_q;    // data arrives this cycle

    chan_state_e            wr_state_q;
    logic [`MEM_ADDR_W-1:0] wr_addr_q;
    logic [7:0]             wr_beat_q;
    logic [BE_W-1:0]        wr_be;

    // read side: issue back to back, data comes one cycle later
    assign mem_rd_en_o   = (rd_state_q == CH_BUSY) && rd_ch.valid &&
                           (rd_issued_q <= {1'b0, rd_ch.len});
    assign mem_rd_addr_o = rd_addr_q[`MEM_IDX_W+2:3];
    assign rd_ch.ready   = rd_pend_q && rd_ch.valid; // cancel drops in-flight data
    assign rd_ch.last    = rd_ch.ready && (rd_beat_q == rd_ch.len);
    assign rd_ch.rdata   = mem_rd_data_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state_q  <= CH_IDLE;
            rd_pend_q   <= 1'b0;
            rd_issued_q <= '0;
            rd_beat_q   <= '0;
        end else begin
            case (rd_state_q)
                CH_IDLE: begin
                    if (rd_ch.valid) begin
                        rd_state_q  <= CH_BUSY;
                        rd_addr_q   <= rd_ch.addr;
                        rd_issued_q <= '0;
                        rd_beat_q   <= '0;
                    end
                end
                CH_BUSY: begin
                    if (!rd_ch.valid || rd_ch.last) begin
                        rd_state_q <= CH_IDLE;
                        rd_pend_q  <= 1'b0;
                    end else begin
                        rd_pend_q <= mem_rd_en_o;
                        if (mem_rd_en_o) begin
                            rd_addr_q   <= rd_addr_q + `MEM_ADDR_W'(8);
                            rd_issued_q <= rd_issued_q + 9'd1;
                        end
                        if (rd_ch.ready) rd_beat_q <= rd_beat_q + 8'd1;
                    end
                end
                default: rd_state_q <= CH_IDLE;
            endcase
        end
    end

    // byte lanes from size and low address bits
    always_comb begin
        case (wr_ch.size)
            SZ_1:    wr_be = BE_W'(8'h01) << wr_addr_q[2:0];
            SZ_2:    wr_be = BE_W'(8'h03) << {wr_addr_q[2:1], 1'b0};
            SZ_4:    wr_be = BE_W'(8'h0f) << {wr_addr_q[2], 2'b00};
            default: wr_be = '1;
        endcase
    end

    // write side: one beat per cycle
    assign mem_wr_en_o   = (wr_state_q == CH_BUSY) && wr_ch.valid;
    assign mem_wr_addr_o = wr_addr_q[`MEM_IDX_W+2:3];
    assign mem_wr_be_o   = wr_be;
    assign mem_wr_data_o = wr_ch.wdata;
    assign wr_ch.ready   = mem_wr_en_o;
    assign wr_ch.last    = mem_wr_en_o && (wr_beat_q == wr_ch.len);
    assign wr_ch.rdata   = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state_q <= CH_IDLE;
            wr_beat_q  <= '0;
        end else begin
            case (wr_state_q)
                CH_IDLE: begin
                    if (wr_ch.valid) begin
                        wr_state_q <= CH_BUSY;
                        wr_addr_q  <= wr_ch.addr;
                        wr_beat_q  <= '0;
                    end
                end
                CH_BUSY: begin
                    if (!wr_ch.valid || wr_ch.last) begin
                        wr_state_q <= CH_IDLE;
                    end else begin
                        wr_addr_q <= wr_addr_q + `MEM_ADDR_W'(8); // low bits kept
                        wr_beat_q <= wr_beat_q + 8'd1;
                    end
                end
                default: wr_state_q <= CH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== mem_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_sub_cfg.svh"

module mem_array (
    input  logic                   clk,
    input  logic                   rd_en_i,
    input  logic [`MEM_IDX_W-1:0]  rd_addr_i,
    output logic [`MEM_DATA_W-1:0] rd_data_o,
    input  logic                   wr_en_i,
    input  logic [`MEM_IDX_W-1:0]  wr_addr_i,
    input  logic [`MEM_BE_W-1:0]   wr_be_i,
    input  logic [`MEM_DATA_W-1:0] wr_data_i
);

    logic [`MEM_DATA_W-1:0] mem_q [`MEM_DEPTH_WORDS];

    // registered read, output held between reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

    // byte-masked write
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < `MEM_BE_W; b++) begin
                if (wr_be_i[b]) begin
                    mem_q[wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_sub_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_sub_cfg.svh"

module mem_sub_top (
    input  logic                   clk,
    input  logic                   rst,
    // fetch
    input  logic                   if_valid_i,
    input  logic [`MEM_ADDR_W-1:0] if_addr_i,
    input  logic [7:0]             if_len_i,
    output logic                   if_ready_o,
    output logic [`MEM_DATA_W-1:0] if_data_o,
    output logic                   if_last_o,
    // data read
    input  logic                   memr_valid_i,
    input  logic [`MEM_ADDR_W-1:0] memr_addr_i,
    input  logic [7:0]             memr_len_i,
    output logic                   memr_ready_o,
    output logic [`MEM_DATA_W-1:0] memr_data_o,
    output logic                   memr_last_o,
    // data write
    input  logic                   memw_valid_i,
    input  logic [`MEM_ADDR_W-1:0] memw_addr_i,
    input  logic [7:0]             memw_len_i,
    input  mem_sub_pkg::size_e     memw_size_i,
    input  logic [`MEM_DATA_W-1:0] memw_data_i,
    output logic                   memw_ready_o,
    output logic                   memw_last_o
);

    logic                   mem_rd_en;
    logic [`MEM_IDX_W-1:0]  mem_rd_addr;
    logic [`MEM_DATA_W-1:0] mem_rd_data;
    logic                   mem_wr_en;
    logic [`MEM_IDX_W-1:0]  mem_wr_addr;
    logic [`MEM_BE_W-1:0]   mem_wr_be;
    logic [`MEM_DATA_W-1:0] mem_wr_data;

    burst_if rd_ch ();
    burst_if wr_ch ();

    bus_arbiter u_bus_arbiter (
        .clk          (clk),
        .rst          (rst),
        .if_valid_i   (if_valid_i),
        .if_addr_i    (if_addr_i),
        .if_len_i     (if_len_i),
        .if_ready_o   (if_ready_o),
        .if_data_o    (if_data_o),
        .if_last_o    (if_last_o),
        .memr_valid_i (memr_valid_i),
        .memr_addr_i  (memr_addr_i),
        .memr_len_i   (memr_len_i),
        .memr_ready_o (memr_ready_o),
        .memr_data_o  (memr_data_o),
        .memr_last_o  (memr_last_o),
        .memw_valid_i (memw_valid_i),
        .memw_addr_i  (memw_addr_i),
        .memw_len_i   (memw_len_i),
        .memw_size_i  (memw_size_i),
        .memw_data_i  (memw_data_i),
        .memw_ready_o (memw_ready_o),
        .memw_last_o  (memw_last_o),
        .rd_ch        (rd_ch),
        .wr_ch        (wr_ch)
    );

    burst_engine u_burst_engine (
        .clk           (clk),
        .rst           (rst),
        .rd_ch         (rd_ch),
        .wr_ch         (wr_ch),
        .mem_rd_en_o   (mem_rd_en),
        .mem_rd_addr_o (mem_rd_addr),
        .mem_rd_data_i (mem_rd_data),
        .mem_wr_en_o   (mem_wr_en),
        .mem_wr_addr_o (mem_wr_addr),
        .mem_wr_be_o   (mem_wr_be),
        .mem_wr_data_o (mem_wr_data)
    );

    mem_array u_mem_array (
        .clk       (clk),
        .rd_en_i   (mem_rd_en),
        .rd_addr_i (mem_rd_addr),
        .rd_data_o (mem_rd_data),
        .wr_en_i   (mem_wr_en),
        .wr_addr_i (mem_wr_addr),
        .wr_be_i   (mem_wr_be),
        .wr_data_i (mem_wr_data)
    );

endmodule

`default_nettype wire

// ==== mem_sub_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sub_assertions (
    input logic                     clk,
    input logic                     rst,
    input mem_sub_pkg::chan_state_e rd_state_i,
    input mem_sub_pkg::grant_e      rd_owner_i,
    input logic                     if_valid_i,
    input logic                     memr_valid_i,
    input logic                     if_ready_i,
    input logic                     if_last_i,
    input logic                     memr_ready_i,
    input logic                     memr_last_i,
    input logic                     memw_ready_i,
    input logic                     memw_last_i
);
    import mem_sub_pkg::*;

    logic owner_valid;
    logic owner_last;

    assign owner_valid = (rd_owner_i == GNT_MEMR) ? memr_valid_i :
                         (rd_owner_i == GNT_IF) ? if_valid_i : 1'b0;
    assign owner_last  = if_last_i | memr_last_i;

    // ready reaches only an owner that is still requesting
    memr_ready_owned: assert property (@(posedge clk) disable iff (rst)
        memr_ready_i |-> rd_owner_i == GNT_MEMR && memr_valid_i)
        else $error("data read saw ready without holding the grant with valid high");

    if_ready_owned: assert property (@(posedge clk) disable iff (rst)
        if_ready_i |-> rd_owner_i == GNT_IF && if_valid_i)
        else $error("fetch saw ready without holding the grant with valid high");

    if_last_with_ready: assert property (@(posedge clk) disable iff (rst)
        if_last_i |-> if_ready_i)
        else $error("fetch last without ready");

    memr_last_with_ready: assert property (@(posedge clk) disable iff (rst)
        memr_last_i |-> memr_ready_i)
        else $error("data read last without ready");

    memw_last_with_ready: assert property (@(posedge clk) disable iff (rst)
        memw_last_i |-> memw_ready_i)
        else $error("write last without ready");

    // mid-burst the owner keeps the channel
    grant_held: assert property (@(posedge clk) disable iff (rst)
        (rd_state_i == CH_BUSY && owner_valid && !owner_last) |=> $stable(rd_owner_i))
        else $error("read grant changed in the middle of a burst");

endmodule

bind bus_arbiter mem_sub_assertions u_mem_sub_assertions (
    .clk          (clk),
    .rst          (rst),
    .rd_state_i   (rd_state_q),
    .rd_owner_i   (rd_owner_q),
    .if_valid_i   (if_valid_i),
    .memr_valid_i (memr_valid_i),
    .if_ready_i   (if_ready_o),
    .if_last_i    (if_last_o),
    .memr_ready_i (memr_ready_o),
    .memr_last_i  (memr_last_o),
    .memw_ready_i (memw_ready_o),
    .memw_last_i  (memw_last_o)
);

`default_nettype wire

// ==== tb_mem_sub.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_sub_cfg.svh"

module tb_mem_sub;
    import mem_sub_pkg::*;

    localparam int MAX_CYCLES = 20000; // traffic below needs roughly 2k cycles
    localparam int NBYTES     = `MEM_DEPTH_WORDS * 8;
    localparam int IDX_W      = `MEM_IDX_W;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   if_valid_i;
    logic [`MEM_ADDR_W-1:0] if_addr_i;
    logic [7:0]             if_len_i;
    logic                   if_ready_o;
    logic [`MEM_DATA_W-1:0] if_data_o;
    logic                   if_last_o;
    logic                   memr_valid_i;
    logic [`MEM_ADDR_W-1:0] memr_addr_i;
    logic [7:0]             memr_len_i;
    logic                   memr_ready_o;
    logic [`MEM_DATA_W-1:0] memr_data_o;
    logic                   memr_last_o;
    logic                   memw_valid_i;
    logic [`MEM_ADDR_W-1:0] memw_addr_i;
    logic [7:0]             memw_len_i;
    size_e                  memw_size_i;
    logic [`MEM_DATA_W-1:0] memw_data_i;
    logic                   memw_ready_o;
    logic                   memw_last_o;

    logic [7:0]             ref_mem [NBYTES];  // byte model of the array
    logic [`MEM_DATA_W-1:0] wr_buf [8];        // beats of the next write burst
    logic [31:0]            lcg_state = 32'd77756;
    int                     cycle_cnt = 0;

    mem_sub_top u_mem_sub_top (
        .clk          (clk),
        .rst          (rst),
        .if_valid_i   (if_valid_i),
        .if_addr_i    (if_addr_i),
        .if_len_i     (if_len_i),
        .if_ready_o   (if_ready_o),
        .if_data_o    (if_data_o),
        .if_last_o    (if_last_o),
        .memr_valid_i (memr_valid_i),
        .memr_addr_i  (memr_addr_i),
        .memr_len_i   (memr_len_i),
        .memr_ready_o (memr_ready_o),
        .memr_data_o  (memr_data_o),
        .memr_last_o  (memr_last_o),
        .memw_valid_i (memw_valid_i),
        .memw_addr_i  (memw_addr_i),
        .memw_len_i   (memw_len_i),
        .memw_size_i  (memw_size_i),
        .memw_data_i  (memw_data_i),
        .memw_ready_o (memw_ready_o),
        .memw_last_o  (memw_last_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run("timeout: the bursts did not complete within the cycle limit");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string test, input logic [`MEM_DATA_W-1:0] want,
                                   input logic [`MEM_DATA_W-1:0] got);
        $display("Error: %s expected %h actual %h", test, want, got);
        abort_run("read data differs from the reference model");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only since the low LCG bits cycle fast
    function automatic int rand_range(input int n);
        return int'(lcg_next() >> 16) % n;
    endfunction

    function automatic void fill_wr_buf();
        for (int i = 0; i < 8; i++) begin
            wr_buf[i][63:32] = lcg_next();
            wr_buf[i][31:0]  = lcg_next();
        end
    endfunction

    function automatic int size_bytes(input size_e size);
        case (size)
            SZ_1:    return 1;
            SZ_2:    return 2;
            SZ_4:    return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic [`MEM_DATA_W-1:0] model_word(input logic [`MEM_IDX_W-1:0] widx);
        logic [`MEM_DATA_W-1:0] w;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = ref_mem[{widx, 3'(b)}];
        end
        return w;
    endfunction

    // byte lanes start at off aligned to the size
    task automatic write_burst(input string name, input int widx, input int off,
                               input int len, input size_e size);
        int                    beat;
        int                    nbytes;
        bit                    done;
        logic [`MEM_IDX_W-1:0] w;
        beat   = 0;
        done   = 1'b0;
        nbytes = size_bytes(size);
        @(negedge clk);
        memw_addr_i  = (32'(widx) << 3) | 32'(off);
        memw_len_i   = 8'(len);
        memw_size_i  = size;
        memw_data_i  = wr_buf[0];
        memw_valid_i = 1'b1;
        while (!done) begin
            @(posedge clk);
            if (memw_ready_o) begin
                w = IDX_W'(widx + beat);
                for (int b = off; b < off + nbytes; b++) begin
                    ref_mem[{w, 3'(b)}] = wr_buf[beat][b*8 +: 8];
                end
                assert (memw_last_o == (beat == len))
                    else abort_run({name, ": write last flag on the wrong beat"});
                done = memw_last_o;
                beat++;
            end
            @(negedge clk);
            if (done) begin
                memw_valid_i = 1'b0;
            end else begin
                memw_data_i = wr_buf[beat]; // next beat only after ready
            end
        end
    endtask

    // cancel_at below zero runs the burst to last
    task automatic read_burst(input string name, input bit fetch, input int widx,
                              input int len, input int cancel_at,
                              output int first_cyc, output int last_cyc);
        int                     beat;
        bit                     done;
        logic                   rdy;
        logic                   lst;
        logic [`MEM_DATA_W-1:0] got;
        logic [`MEM_DATA_W-1:0] want;
        beat      = 0;
        done      = 1'b0;
        first_cyc = -1;
        last_cyc  = -1;
        @(negedge clk);
        if (fetch) begin
            if_addr_i  = 32'(widx) << 3;
            if_len_i   = 8'(len);
            if_valid_i = 1'b1;
        end else begin
            memr_addr_i  = 32'(widx) << 3;
            memr_len_i   = 8'(len);
            memr_valid_i = 1'b1;
        end
        while (!done) begin
            @(posedge clk);
            rdy = fetch ? if_ready_o : memr_ready_o;
            lst = fetch ? if_last_o : memr_last_o;
            got = fetch ? if_data_o : memr_data_o;
            if (rdy) begin
                want = model_word(IDX_W'(widx + beat));
                if (first_cyc < 0) begin
                    first_cyc = cycle_cnt;
                end
                assert (got === want) else report_mismatch(name, want, got);
                assert (lst == (beat == len))
                    else abort_run({name, ": read last flag on the wrong beat"});
                beat++;
                last_cyc = cycle_cnt;
                done     = lst || (beat == cancel_at);
            end
        end
        @(negedge clk);
        if (fetch) begin
            if_valid_i = 1'b0;
        end else begin
            memr_valid_i = 1'b0;
        end
    endtask

    initial begin
        int    first_a;
        int    last_a;
        int    first_b;
        int    last_b;
        int    widx;
        int    len;
        int    fidx;
        int    flen;
        int    off;
        int    cut;
        size_e sz;
        rst          = 1'b1;
        if_valid_i   = 1'b0;
        if_addr_i    = '0;
        if_len_i     = '0;
        memr_valid_i = 1'b0;
        memr_addr_i  = '0;
        memr_len_i   = '0;
        memw_valid_i = 1'b0;
        memw_addr_i  = '0;
        memw_len_i   = '0;
        memw_size_i  = SZ_8;
        memw_data_i  = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // whole array gets known contents first
        for (int w = 0; w < `MEM_DEPTH_WORDS; w += 8) begin
            fill_wr_buf();
            write_burst("preload", w, 0, 7, SZ_8);
        end

        for (int i = 0; i < 12; i++) begin
            widx = rand_range(`MEM_DEPTH_WORDS);
            len  = rand_range(8);
            fill_wr_buf();
            write_burst("full_write", widx, 0, len, SZ_8);
            read_burst("full_readback", 1'b0, widx, len, -1, first_a, last_a);
        end

        // partial lanes leave the other bytes at their model values
        for (int i = 0; i < 12; i++) begin
            case (i % 3)
                0:       sz = SZ_1;
                1:       sz = SZ_2;
                default: sz = SZ_4;
            endcase
            widx = rand_range(`MEM_DEPTH_WORDS);
            len  = rand_range(8);
            off  = rand_range(8) & ~(size_bytes(sz) - 1);
            fill_wr_buf();
            write_burst("partial_write", widx, off, len, sz);
            read_burst("partial_readback", 1'b0, widx, len, -1, first_a, last_a);
        end

        for (int i = 0; i < 10; i++) begin
            widx = rand_range(`MEM_DEPTH_WORDS);
            len  = rand_range(8);
            read_burst("fetch_read", 1'b1, widx, len, -1, first_a, last_a);
        end

        // same-cycle requests where the data read has priority
        for (int i = 0; i < 6; i++) begin
            widx = rand_range(`MEM_DEPTH_WORDS);
            len  = rand_range(8);
            fidx = rand_range(`MEM_DEPTH_WORDS);
            flen = rand_range(8);
            fork
                read_burst("race_data_read", 1'b0, widx, len, -1, first_a, last_a);
                read_burst("race_fetch", 1'b1, fidx, flen, -1, first_b, last_b);
            join
            assert (last_a < first_b)
                else abort_run("fetch got ready before the data read burst ended");
        end

        // writes in the lower half and fetches in the upper half
        for (int i = 0; i < 6; i++) begin
            widx = rand_range(121);
            len  = rand_range(8);
            fidx = 128 + rand_range(121);
            flen = rand_range(8);
            fill_wr_buf();
            fork
                write_burst("overlap_write", widx, 0, len, SZ_8);
                read_burst("overlap_fetch", 1'b1, fidx, flen, -1, first_b, last_b);
            join
            read_burst("overlap_readback", 1'b0, widx, len, -1, first_a, last_a);
        end

        for (int i = 0; i < 6; i++) begin
            widx = rand_range(`MEM_DEPTH_WORDS);
            len  = 3 + rand_range(5);
            cut  = 1 + rand_range(len);
            read_burst("cancel_read", (i % 2 == 1), widx, len, cut, first_a, last_a);
            widx = rand_range(`MEM_DEPTH_WORDS);
            len  = rand_range(8);
            read_burst("after_cancel", 1'b0, widx, len, -1, first_a, last_a);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
mem_sub_pkg.sv
burst_if.sv
bus_arbiter.sv
burst_engine.sv
mem_array.sv
mem_sub_top.sv
mem_sub_assertions.sv
tb_mem_sub.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := tb_mem_sub
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
